//--- logic/packet_fifo.sv
`timescale 1ns/1ps

module packet_fifo #(
    parameter type payload_t = logic [63:0],
    parameter int  DEPTH     = 2
) (
    input  logic     clk,
    input  logic     nreset,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t        mem [DEPTH];
    logic [PW-1:0]   wr_ptr;
    logic [PW-1:0]   rd_ptr;
    logic [CW-1:0]   count;
    logic            push;
    logic            pop;

    assign in_ready  = (count != CW'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    assign push = in_valid & in_ready;
    assign pop  = out_valid & out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- logic/tl2umi_bridge.sv
`timescale 1ns/1ps

module tl2umi_bridge
    import tl_pkg::*;
    import umi_pkg::*;
#(
    parameter int REQ_DEPTH  = 2,
    parameter int RESP_DEPTH = 2
) (
    input  logic              clk,
    input  logic              nreset,
    input  logic [UMI_AW-1:0] srcaddr,

    input  logic              tl_a_valid,
    input  tl_a_t             tl_a,
    output logic              tl_a_ready,

    output logic              tl_d_valid,
    output tl_d_t             tl_d,
    input  logic              tl_d_ready,
    output logic [1:0]        tl_d_param,
    output logic              tl_d_sink,
    output logic              tl_d_denied,
    output logic              tl_d_corrupt,

    output logic              uhost_req_valid,
    output umi_packet_t       uhost_req,
    input  logic              uhost_req_ready,

    input  logic              uhost_resp_valid,
    input  umi_packet_t       uhost_resp,
    output logic              uhost_resp_ready
);

    logic        req_pkt_valid;
    umi_packet_t req_pkt;
    logic        req_pkt_ready;
    logic        resp_pkt_valid;
    umi_packet_t resp_pkt;
    logic        resp_pkt_ready;
    logic        txn_done;

    assign tl_d_param   = 2'b00;
    assign tl_d_sink    = 1'b0;
    assign tl_d_denied  = 1'b0;
    assign tl_d_corrupt = 1'b0;

    tl_req_converter req_conv (
        .clk        (clk),
        .nreset     (nreset),
        .srcaddr    (srcaddr),
        .tl_a_valid (tl_a_valid),
        .tl_a       (tl_a),
        .tl_a_ready (tl_a_ready),
        .req_valid  (req_pkt_valid),
        .req        (req_pkt),
        .req_ready  (req_pkt_ready),
        .txn_done   (txn_done)
    );

    packet_fifo #(
        .payload_t (umi_packet_t),
        .DEPTH     (REQ_DEPTH)
    ) req_fifo (
        .clk       (clk),
        .nreset    (nreset),
        .in_valid  (req_pkt_valid),
        .in_data   (req_pkt),
        .in_ready  (req_pkt_ready),
        .out_valid (uhost_req_valid),
        .out_data  (uhost_req),
        .out_ready (uhost_req_ready)
    );

    packet_fifo #(
        .payload_t (umi_packet_t),
        .DEPTH     (RESP_DEPTH)
    ) resp_fifo (
        .clk       (clk),
        .nreset    (nreset),
        .in_valid  (uhost_resp_valid),
        .in_data   (uhost_resp),
        .in_ready  (uhost_resp_ready),
        .out_valid (resp_pkt_valid),
        .out_data  (resp_pkt),
        .out_ready (resp_pkt_ready)
    );

    umi_resp_converter resp_conv (
        .clk        (clk),
        .nreset     (nreset),
        .resp_valid (resp_pkt_valid),
        .resp       (resp_pkt),
        .resp_ready (resp_pkt_ready),
        .tl_d_valid (tl_d_valid),
        .tl_d       (tl_d),
        .tl_d_ready (tl_d_ready),
        .txn_done   (txn_done)
    );

endmodule

//--- logic/tl_pkg.sv
package tl_pkg;

    // A and D opcodes overlap in encoding
    typedef logic [2:0] tl_opcode_e;

    // A channel
    localparam tl_opcode_e TL_PUT_FULL_DATA    = 3'd0;
    localparam tl_opcode_e TL_PUT_PARTIAL_DATA = 3'd1;
    localparam tl_opcode_e TL_ARITHMETIC_DATA  = 3'd2;
    localparam tl_opcode_e TL_LOGICAL_DATA     = 3'd3;
    localparam tl_opcode_e TL_GET              = 3'd4;

    // D channel
    localparam tl_opcode_e TL_ACCESS_ACK       = 3'd0;
    localparam tl_opcode_e TL_ACCESS_ACK_DATA  = 3'd1;

    typedef enum logic [2:0] {
        TL_PA_MIN  = 3'd0,
        TL_PA_MAX  = 3'd1,
        TL_PA_MINU = 3'd2,
        TL_PA_MAXU = 3'd3,
        TL_PA_ADD  = 3'd4
    } tl_arith_param_e;

    typedef enum logic [2:0] {
        TL_PL_XOR  = 3'd0,
        TL_PL_OR   = 3'd1,
        TL_PL_AND  = 3'd2,
        TL_PL_SWAP = 3'd3
    } tl_logic_param_e;

    typedef struct packed {
        tl_opcode_e  opcode;
        logic [2:0]  param;
        logic [2:0]  size;
        logic [4:0]  source;
        logic [55:0] address;
        logic [7:0]  mask;
        logic [63:0] data;
    } tl_a_t;

    typedef struct packed {
        tl_opcode_e  opcode;
        logic [2:0]  size;
        logic [4:0]  source;
        logic [63:0] data;
    } tl_d_t;

endpackage

//--- logic/tl_req_converter.sv
`timescale 1ns/1ps

module tl_req_converter
    import tl_pkg::*;
    import umi_pkg::*;
(
    input  logic              clk,
    input  logic              nreset,
    input  logic [UMI_AW-1:0] srcaddr,
    input  logic              tl_a_valid,
    input  tl_a_t             tl_a,
    output logic              tl_a_ready,
    output logic              req_valid,
    output umi_packet_t       req,
    input  logic              req_ready,
    input  logic              txn_done
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_WAIT_DONE
    } state_e;

    state_e      state;
    logic [2:0]  shift;
    logic [3:0]  ones;
    logic        a_fire;
    logic        a_supported;
    logic        atomic_ok;
    umi_atype_e  atype;
    umi_user_t   user;
    umi_packet_t pkt_next;

    assign tl_a_ready = (state == ST_IDLE);
    assign req_valid  = (state == ST_ISSUE);
    assign a_fire     = tl_a_valid & tl_a_ready;

    assign a_supported = (tl_a.opcode == TL_GET) ||
                         (tl_a.opcode == TL_PUT_FULL_DATA) ||
                         (tl_a.opcode == TL_PUT_PARTIAL_DATA) ||
                         (tl_a.opcode == TL_ARITHMETIC_DATA) ||
                         (tl_a.opcode == TL_LOGICAL_DATA);

    // Lowest set mask bit is the start byte
    always_comb begin
        shift = 3'd0;
        for (int i = 7; i >= 0; i--) begin
            if (tl_a.mask[i]) begin
                shift = 3'(i);
            end
        end
    end

    always_comb begin
        ones = '0;
        for (int i = 0; i < 8; i++) begin
            ones = ones + 4'(tl_a.mask[i]);
        end
    end

    // Atomic type from opcode and param
    always_comb begin
        atype     = UMI_ATOMIC_ADD;
        atomic_ok = 1'b1;
        if (tl_a.opcode == TL_ARITHMETIC_DATA) begin
            case (tl_a.param)
                TL_PA_MIN:  atype = UMI_ATOMIC_MIN;
                TL_PA_MAX:  atype = UMI_ATOMIC_MAX;
                TL_PA_MINU: atype = UMI_ATOMIC_MINU;
                TL_PA_MAXU: atype = UMI_ATOMIC_MAXU;
                TL_PA_ADD:  atype = UMI_ATOMIC_ADD;
                default:    atomic_ok = 1'b0;
            endcase
        end else begin
            case (tl_a.param)
                TL_PL_XOR:  atype = UMI_ATOMIC_XOR;
                TL_PL_OR:   atype = UMI_ATOMIC_OR;
                TL_PL_AND:  atype = UMI_ATOMIC_AND;
                TL_PL_SWAP: atype = UMI_ATOMIC_SWAP;
                default:    atomic_ok = 1'b0;
            endcase
        end
    end

    assign user.shift  = {1'b0, shift};
    assign user.size   = {1'b0, tl_a.size};
    assign user.source = {3'b000, tl_a.source};

    always_comb begin
        pkt_next.cmd.rsvd   = '0;
        pkt_next.cmd.eom    = 1'b1;
        pkt_next.cmd.atype  = UMI_ATOMIC_ADD;
        pkt_next.cmd.len    = 8'(ones - 4'd1);
        pkt_next.cmd.size   = 3'd0;
        pkt_next.cmd.opcode = UMI_REQ_WRITE;
        pkt_next.dstaddr    = {8'h00, tl_a.address[55:3], shift};
        pkt_next.srcaddr    = {srcaddr[UMI_AW-1:16], user};
        pkt_next.data       = tl_a.data >> {shift, 3'b000};
        case (tl_a.opcode)
            TL_GET: begin
                pkt_next.cmd.opcode = UMI_REQ_READ;
                pkt_next.cmd.len    = (8'd1 << tl_a.size) - 8'd1;
            end
            TL_ARITHMETIC_DATA, TL_LOGICAL_DATA: begin
                pkt_next.cmd.opcode = atomic_ok ? UMI_REQ_ATOMIC : UMI_REQ_ERROR;
                pkt_next.cmd.size   = tl_a.size;
                pkt_next.cmd.len    = 8'd0;
                pkt_next.cmd.atype  = atype;
            end
            default: begin
                pkt_next.cmd.opcode = UMI_REQ_WRITE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (a_fire) begin
            req <= pkt_next;
        end
    end

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    // Unsupported opcodes are taken and dropped
                    if (a_fire && a_supported) begin
                        state <= ST_ISSUE;
                    end
                end
                ST_ISSUE: begin
                    if (req_ready) begin
                        state <= ST_WAIT_DONE;
                    end
                end
                ST_WAIT_DONE: begin
                    if (txn_done) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

//--- logic/umi_pkg.sv
package umi_pkg;

    localparam int UMI_AW = 64;
    localparam int UMI_DW = 64;

    typedef enum logic [4:0] {
        UMI_REQ_READ   = 5'h01,
        UMI_RESP_READ  = 5'h02,
        UMI_REQ_WRITE  = 5'h03,
        UMI_RESP_WRITE = 5'h04,
        UMI_REQ_ATOMIC = 5'h09,
        UMI_REQ_ERROR  = 5'h0f
    } umi_opcode_e;

    typedef enum logic [7:0] {
        UMI_ATOMIC_ADD  = 8'h00,
        UMI_ATOMIC_AND  = 8'h01,
        UMI_ATOMIC_OR   = 8'h02,
        UMI_ATOMIC_XOR  = 8'h03,
        UMI_ATOMIC_MAX  = 8'h04,
        UMI_ATOMIC_MIN  = 8'h05,
        UMI_ATOMIC_MAXU = 8'h06,
        UMI_ATOMIC_MINU = 8'h07,
        UMI_ATOMIC_SWAP = 8'h08
    } umi_atype_e;

    typedef struct packed {
        logic [6:0]  rsvd;
        logic        eom;
        umi_atype_e  atype;
        logic [7:0]  len;
        logic [2:0]  size;
        umi_opcode_e opcode;
    } umi_cmd_t;

    typedef struct packed {
        umi_cmd_t          cmd;
        logic [UMI_AW-1:0] dstaddr;
        logic [UMI_AW-1:0] srcaddr;
        logic [UMI_DW-1:0] data;
    } umi_packet_t;

    // Low 16 bits of the request source address, echoed back in the
    // response destination address
    typedef struct packed {
        logic [3:0] shift;
        logic [3:0] size;
        logic [7:0] source;
    } umi_user_t;

endpackage

//--- logic/umi_resp_converter.sv
`timescale 1ns/1ps

module umi_resp_converter
    import tl_pkg::*;
    import umi_pkg::*;
(
    input  logic        clk,
    input  logic        nreset,
    input  logic        resp_valid,
    input  umi_packet_t resp,
    output logic        resp_ready,
    output logic        tl_d_valid,
    output tl_d_t       tl_d,
    input  logic        tl_d_ready,
    output logic        txn_done
);

    umi_user_t user;
    logic      resp_fire;
    logic      is_read;
    logic      is_write;

    // Source, size and shift come back in the destination address
    assign user = resp.dstaddr[15:0];

    assign resp_ready = ~tl_d_valid;
    assign resp_fire  = resp_valid & resp_ready;
    assign txn_done   = tl_d_valid & tl_d_ready;

    assign is_read  = (resp.cmd.opcode == UMI_RESP_READ);
    assign is_write = (resp.cmd.opcode == UMI_RESP_WRITE);

    always_ff @(posedge clk) begin
        if (resp_fire) begin
            tl_d.size   <= user.size[2:0];
            tl_d.source <= user.source[4:0];
            if (is_read) begin
                tl_d.opcode <= TL_ACCESS_ACK_DATA;
                tl_d.data   <= resp.data << {user.shift, 3'b000};
            end else begin
                tl_d.opcode <= TL_ACCESS_ACK;
                tl_d.data   <= '0;
            end
        end
    end

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            tl_d_valid <= 1'b0;
        end else if (resp_fire) begin
            // Other response types are dropped without a D beat
            tl_d_valid <= is_read | is_write;
        end else if (tl_d_ready) begin
            tl_d_valid <= 1'b0;
        end
    end

endmodule

//--- src.f
logic/tl_pkg.sv
logic/umi_pkg.sv
logic/packet_fifo.sv
logic/tl_req_converter.sv
logic/umi_resp_converter.sv
logic/tl2umi_bridge.sv
tb/tb_clkgen.sv
tb/tl2umi_asserts.sv
tb/tb_tl2umi.sv

//--- tb/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk,
    output logic nreset
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held for 10 cycles
    initial begin
        nreset = 1'b0;
        repeat (10) @(posedge clk);
        nreset <= 1'b1;
    end

endmodule

//--- tb/tb_tl2umi.sv
`timescale 1ns/1ps

module tb_tl2umi
    import tl_pkg::*;
    import umi_pkg::*;
();

    localparam logic [63:0] SRCADDR = 64'hABCD_0123_4567_FFFF;
    localparam int TIMEOUT  = 200;
    localparam int EV_RESET = 0;
    localparam int EV_A     = 1;
    localparam int EV_REQ_V = 2;
    localparam int EV_REQ   = 3;
    localparam int EV_RESP  = 4;
    localparam int EV_D_V   = 5;
    localparam int EV_D     = 6;

    typedef struct {
        string       name;
        tl_a_t       a;
        umi_opcode_e op;
        logic [7:0]  len;
        logic [2:0]  size;
        umi_atype_e  atype;
        logic [63:0] dst;
        logic [63:0] data;
        logic [15:0] user;
        logic [63:0] rdata;
        tl_opcode_e  d_op;
        logic [63:0] d_data;
        logic        d_stall;
    } row_t;

    logic        clk;
    logic        nreset;
    logic [63:0] srcaddr;
    logic        tl_a_valid;
    tl_a_t       tl_a;
    logic        tl_a_ready;
    logic        tl_d_valid;
    tl_d_t       tl_d;
    logic        tl_d_ready;
    logic [1:0]  tl_d_param;
    logic        tl_d_sink;
    logic        tl_d_denied;
    logic        tl_d_corrupt;
    logic        uhost_req_valid;
    umi_packet_t uhost_req;
    logic        uhost_req_ready;
    logic        uhost_resp_valid;
    umi_packet_t uhost_resp;
    logic        uhost_resp_ready;

    row_t   rows[$];
    integer seed = 32'h1768_4bd1;
    int     errors = 0;
    int     checks = 0;

    tb_clkgen clkgen (.clk(clk), .nreset(nreset));

    tl2umi_bridge #(.REQ_DEPTH(2), .RESP_DEPTH(2)) i_dut (.*);

    task automatic compare(input string name, input string what,
                           input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAIL %s %s: expected %h, actual %h", name, what, exp, act);
        end
    endtask

    task automatic wait_event(input int ev, input string what);
        int   n;
        logic hit;
        n   = 0;
        hit = 1'b0;
        while (hit !== 1'b1 && n < TIMEOUT) begin
            @(posedge clk);
            n++;
            case (ev)
                EV_RESET: hit = nreset;
                EV_A:     hit = tl_a_valid && tl_a_ready;
                EV_REQ_V: hit = uhost_req_valid;
                EV_REQ:   hit = uhost_req_valid && uhost_req_ready;
                EV_RESP:  hit = uhost_resp_valid && uhost_resp_ready;
                EV_D_V:   hit = tl_d_valid;
                default:  hit = tl_d_valid && tl_d_ready;
            endcase
        end
        if (hit !== 1'b1) begin
            $display("Timeout after %0d cycles waiting for %s", TIMEOUT, what);
            $display("SOME TESTS FAILED");
            $finish;
        end
    endtask

    // Gets and Puts always expect UMI size 0
    function automatic void add_row(input string name, input tl_a_t a, input umi_opcode_e op,
                                    input logic [7:0] len, input logic [63:0] dst,
                                    input logic [63:0] data, input logic [15:0] user,
                                    input logic [63:0] rdata, input tl_opcode_e d_op,
                                    input logic [63:0] d_data, input logic d_stall);
        row_t r;
        r = '{name, a, op, len, 3'd0, UMI_ATOMIC_ADD, dst, data, user, rdata, d_op, d_data,
              d_stall};
        rows.push_back(r);
    endfunction

    // Atomics share one 8-byte beat at 0x9000 from source 6
    function automatic void atomic_row(input string name, input tl_opcode_e op,
                                       input logic [2:0] param, input umi_opcode_e exp_op,
                                       input umi_atype_e atype);
        row_t r;
        r = '{name, tl_a_t'{op, param, 3'd3, 5'd6, 56'h9000, 8'hFF, 64'h42}, exp_op, 8'd0,
              3'd3, atype, 64'h9000, 64'h42, 16'h0306, 64'h17, TL_ACCESS_ACK_DATA, 64'h17,
              1'b0};
        rows.push_back(r);
    endfunction

    task automatic run_row(input row_t r);
        umi_packet_t pkt;
        umi_packet_t resp;
        tl_d_t       d;
        int          hold;
        tl_a_valid <= 1'b1;
        tl_a       <= r.a;
        tl_d_ready <= !r.d_stall;
        wait_event(EV_A, "the A handshake");
        tl_a_valid <= 1'b0;

        // Device holds ready low for a few cycles first
        wait_event(EV_REQ_V, "a UMI request");
        pkt  = uhost_req;
        hold = {$random(seed)} % 4;
        repeat (hold) begin
            @(posedge clk);
            compare(r.name, "held request", 1, uhost_req_valid === 1'b1 && uhost_req === pkt);
        end
        uhost_req_ready <= 1'b1;
        wait_event(EV_REQ, "the UMI request handshake");
        uhost_req_ready <= 1'b0;
        pkt = uhost_req;
        compare(r.name, "opcode", r.op, pkt.cmd.opcode);
        compare(r.name, "len", r.len, pkt.cmd.len);
        compare(r.name, "size", r.size, pkt.cmd.size);
        compare(r.name, "eom", 1, pkt.cmd.eom);
        compare(r.name, "rsvd", 0, pkt.cmd.rsvd);
        if (r.op == UMI_REQ_ATOMIC) begin
            compare(r.name, "atype", r.atype, pkt.cmd.atype);
        end
        compare(r.name, "dstaddr", r.dst, pkt.dstaddr);
        compare(r.name, "srcaddr", {SRCADDR[63:16], r.user}, pkt.srcaddr);
        if (r.op != UMI_REQ_READ) begin
            compare(r.name, "data", r.data, pkt.data);
        end
        @(posedge clk);
        compare(r.name, "second request", 0, uhost_req_valid);

        hold = {$random(seed)} % 4;
        repeat (hold) @(posedge clk);
        resp             = '0;
        resp.cmd.opcode  = (pkt.cmd.opcode == UMI_REQ_WRITE) ? UMI_RESP_WRITE : UMI_RESP_READ;
        resp.cmd.eom     = 1'b1;
        resp.dstaddr     = pkt.srcaddr;
        resp.data        = r.rdata;
        uhost_resp_valid <= 1'b1;
        uhost_resp       <= resp;
        wait_event(EV_RESP, "the UMI response handshake");
        uhost_resp_valid <= 1'b0;

        if (r.d_stall) begin
            wait_event(EV_D_V, "the D beat");
            d    = tl_d;
            hold = 1 + {$random(seed)} % 4;
            repeat (hold) begin
                @(posedge clk);
                compare(r.name, "held D beat", 1, tl_d_valid === 1'b1 && tl_d === d);
                compare(r.name, "A ready in stall", 0, tl_a_ready);
            end
            tl_d_ready <= 1'b1;
        end
        wait_event(EV_D, "the D handshake");
        compare(r.name, "d opcode", r.d_op, tl_d.opcode);
        compare(r.name, "d size", r.a.size, tl_d.size);
        compare(r.name, "d source", r.a.source, tl_d.source);
        compare(r.name, "d data", r.d_data, tl_d.data);
        compare(r.name, "d param", 0, tl_d_param);
        compare(r.name, "d sink", 0, tl_d_sink);
        compare(r.name, "d denied", 0, tl_d_denied);
        compare(r.name, "d corrupt", 0, tl_d_corrupt);
        compare(r.name, "A ready at D", 0, tl_a_ready);
    endtask

    initial begin
        srcaddr          = SRCADDR;
        tl_a_valid       = 1'b0;
        tl_a             = '0;
        tl_d_ready       = 1'b1;
        uhost_req_ready  = 1'b0;
        uhost_resp_valid = 1'b0;
        uhost_resp       = '0;

        add_row("get_byte", tl_a_t'{TL_GET, 3'd0, 3'd0, 5'd3, 56'h1005, 8'h20, 64'h0},
                UMI_REQ_READ, 8'd0, 64'h1005, 64'h0, 16'h5003,
                64'hA5, TL_ACCESS_ACK_DATA, 64'h0000_A500_0000_0000, 1'b0);
        add_row("get_half", tl_a_t'{TL_GET, 3'd0, 3'd1, 5'd7, 56'h2002, 8'h0C, 64'h0},
                UMI_REQ_READ, 8'd1, 64'h2002, 64'h0, 16'h2107,
                64'hBEEF, TL_ACCESS_ACK_DATA, 64'h0000_0000_BEEF_0000, 1'b0);
        add_row("get_word", tl_a_t'{TL_GET, 3'd0, 3'd2, 5'd31, 56'hAB_0000_3004, 8'hF0, 64'h0},
                UMI_REQ_READ, 8'd3, 64'hAB_0000_3004, 64'h0, 16'h421F,
                64'h1234_5678, TL_ACCESS_ACK_DATA, 64'h1234_5678_0000_0000, 1'b0);
        add_row("get_dword_stall", tl_a_t'{TL_GET, 3'd0, 3'd3, 5'd0, 56'h4000, 8'hFF, 64'h0},
                UMI_REQ_READ, 8'd7, 64'h4000, 64'h0, 16'h0300,
                64'h0123_4567_89AB_CDEF, TL_ACCESS_ACK_DATA, 64'h0123_4567_89AB_CDEF, 1'b1);
        add_row("put_full", tl_a_t'{TL_PUT_FULL_DATA, 3'd0, 3'd3, 5'd2, 56'h5000, 8'hFF,
                64'hDEAD_BEEF_CAFE_F00D}, UMI_REQ_WRITE, 8'd7, 64'h5000,
                64'hDEAD_BEEF_CAFE_F00D, 16'h0302, 64'h1111, TL_ACCESS_ACK, 64'h0, 1'b0);
        add_row("put_partial_mid", tl_a_t'{TL_PUT_PARTIAL_DATA, 3'd0, 3'd3, 5'd4, 56'h6000,
                8'h18, 64'h1122_3344_5566_7788}, UMI_REQ_WRITE, 8'd1, 64'h6003,
                64'h0000_0011_2233_4455, 16'h3304, 64'h2222, TL_ACCESS_ACK, 64'h0, 1'b1);
        add_row("put_partial_top", tl_a_t'{TL_PUT_PARTIAL_DATA, 3'd0, 3'd0, 5'd9, 56'h7007,
                8'h80, 64'hAB00_0000_0000_0000}, UMI_REQ_WRITE, 8'd0, 64'h7007,
                64'hAB, 16'h7009, 64'h0, TL_ACCESS_ACK, 64'h0, 1'b0);
        add_row("put_partial_sparse", tl_a_t'{TL_PUT_PARTIAL_DATA, 3'd0, 3'd3, 5'd5, 56'h8000,
                8'h41, 64'h0102_0304_0506_0708}, UMI_REQ_WRITE, 8'd1, 64'h8000,
                64'h0102_0304_0506_0708, 16'h0305, 64'h0, TL_ACCESS_ACK, 64'h0, 1'b0);
        atomic_row("amo_min", TL_ARITHMETIC_DATA, TL_PA_MIN, UMI_REQ_ATOMIC, UMI_ATOMIC_MIN);
        atomic_row("amo_max", TL_ARITHMETIC_DATA, TL_PA_MAX, UMI_REQ_ATOMIC, UMI_ATOMIC_MAX);
        atomic_row("amo_minu", TL_ARITHMETIC_DATA, TL_PA_MINU, UMI_REQ_ATOMIC, UMI_ATOMIC_MINU);
        atomic_row("amo_maxu", TL_ARITHMETIC_DATA, TL_PA_MAXU, UMI_REQ_ATOMIC, UMI_ATOMIC_MAXU);
        atomic_row("amo_add", TL_ARITHMETIC_DATA, TL_PA_ADD, UMI_REQ_ATOMIC, UMI_ATOMIC_ADD);
        atomic_row("amo_arith_bad", TL_ARITHMETIC_DATA, 3'd5, UMI_REQ_ERROR, UMI_ATOMIC_ADD);
        atomic_row("amo_xor", TL_LOGICAL_DATA, TL_PL_XOR, UMI_REQ_ATOMIC, UMI_ATOMIC_XOR);
        atomic_row("amo_or", TL_LOGICAL_DATA, TL_PL_OR, UMI_REQ_ATOMIC, UMI_ATOMIC_OR);
        atomic_row("amo_and", TL_LOGICAL_DATA, TL_PL_AND, UMI_REQ_ATOMIC, UMI_ATOMIC_AND);
        atomic_row("amo_swap", TL_LOGICAL_DATA, TL_PL_SWAP, UMI_REQ_ATOMIC, UMI_ATOMIC_SWAP);
        atomic_row("amo_logic_bad", TL_LOGICAL_DATA, 3'd4, UMI_REQ_ERROR, UMI_ATOMIC_ADD);

        wait_event(EV_RESET, "reset release");
        compare("reset", "tl_a_ready", 1, tl_a_ready);
        compare("reset", "uhost_resp_ready", 1, uhost_resp_ready);
        compare("reset", "tl_d_valid", 0, tl_d_valid);
        compare("reset", "uhost_req_valid", 0, uhost_req_valid);

        foreach (rows[i]) begin
            run_row(rows[i]);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- tb/tl2umi_asserts.sv
`timescale 1ns/1ps

module tl2umi_asserts
    import tl_pkg::*;
    import umi_pkg::*;
(
    input logic        clk,
    input logic        nreset,
    input logic        tl_a_valid,
    input tl_a_t       tl_a,
    input logic        tl_a_ready,
    input logic        tl_d_valid,
    input tl_d_t       tl_d,
    input logic        tl_d_ready,
    input logic        uhost_req_valid,
    input umi_packet_t uhost_req,
    input logic        uhost_req_ready,
    input logic        uhost_resp_valid,
    input umi_packet_t uhost_resp,
    input logic        uhost_resp_ready
);

    logic a_supported;

    // Get is the highest supported A opcode
    assign a_supported = (tl_a.opcode <= TL_GET);

    a_hold: assert property (@(posedge clk) disable iff (!nreset)
        tl_a_valid && !tl_a_ready |=> tl_a_valid && $stable(tl_a))
        else $error("A beat changed before its handshake");

    d_hold: assert property (@(posedge clk) disable iff (!nreset)
        tl_d_valid && !tl_d_ready |=> tl_d_valid && $stable(tl_d))
        else $error("D beat changed before its handshake");

    req_hold: assert property (@(posedge clk) disable iff (!nreset)
        uhost_req_valid && !uhost_req_ready |=> uhost_req_valid && $stable(uhost_req))
        else $error("UMI request changed before its handshake");

    resp_hold: assert property (@(posedge clk) disable iff (!nreset)
        uhost_resp_valid && !uhost_resp_ready |=> uhost_resp_valid && $stable(uhost_resp))
        else $error("UMI response changed before its handshake");

    // A channel closes after a request and opens only after a D handshake
    a_close: assert property (@(posedge clk) disable iff (!nreset)
        tl_a_valid && tl_a_ready && a_supported |=> !tl_a_ready)
        else $error("A channel still open after a request");

    a_reopen: assert property (@(posedge clk) disable iff (!nreset)
        $rose(tl_a_ready) |-> $past(tl_d_valid && tl_d_ready))
        else $error("A channel opened without a D handshake");

endmodule

bind tl2umi_bridge tl2umi_asserts asserts (.*);
